//--- rtl/lcd_pkg.sv
package lcd_pkg;

	// display configuration word, msb first
	typedef struct packed {
		logic lines;      // 1 = two display lines
		logic font;       // 1 = 5x10 dot font
		logic display_on;
		logic cursor_on;
		logic blink;      // blink at cursor position
		logic inc_dec;    // 1 = address increments
		logic shift;      // display shifts on entry
	} lcd_cfg_t;

	// one transfer on the parallel bus
	typedef struct packed {
		logic       rs;   // 0 = instruction, 1 = data
		logic       rw;   // passed to the pin only
		logic [7:0] data;
	} lcd_cmd_t;

	// pins toward the display
	typedef struct packed {
		logic       e;
		logic       rs;
		logic       rw;
		logic [7:0] data;
	} lcd_pins_t;

	// power-up delay before the first init command
	localparam int POWERUP_US = 500;
	// minimum length of one command cycle
	localparam int CMD_CYCLE_US = 50;
	// enable pulse window inside a command cycle
	localparam int EN_START_US = 1;
	localparam int EN_END_US = 14;
	// settle time after clear
	localparam int CLEAR_WAIT_US = 200;
	// settle time after entry mode set
	localparam int ENTRY_WAIT_US = 100;
	// e high time of each init command
	localparam int INIT_PULSE_US = 10;

endpackage

//--- rtl/apb_pkg.sv
package apb_pkg;

	// requester side of the bus
	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [3:0]  paddr;   // byte offset in the register window
		logic [31:0] pwdata;
	} apb_req_t;

	// completer side
	typedef struct packed {
		logic [31:0] prdata;
		logic        pready;
		logic        pslverr;
	} apb_rsp_t;

	localparam logic [3:0] REG_CFG = 4'd0;    // display configuration
	localparam logic [3:0] REG_CTRL = 4'd4;   // bit 0 starts init
	localparam logic [3:0] REG_CMD = 4'd8;    // rs, rw, data in bits 9..0
	localparam logic [3:0] REG_STATUS = 4'd12;

endpackage

//--- rtl/lcd_apb_regs.sv
`timescale 1ns/1ps

module lcd_apb_regs #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                      clk,
	input  logic                      rst,
	input  apb_pkg::apb_req_t         req,
	input  logic                      fifo_full,
	input  logic [$clog2(FIFO_DEPTH):0] fifo_level,
	input  logic                      init_done,
	input  logic                      busy,
	output apb_pkg::apb_rsp_t         rsp,
	output lcd_pkg::lcd_cfg_t         cfg,
	output logic                      start,
	output logic                      push,
	output lcd_pkg::lcd_cmd_t         push_data
);
	localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

	logic        setup;
	logic        access;
	logic        wr_access;
	logic        sel_cfg;
	logic        sel_ctrl;
	logic        sel_cmd;
	logic        sel_status;
	logic        sel_known;
	logic        init_running;
	logic [31:0] status_word;
	logic [31:0] rd_mux;
	logic [31:0] rdata_q;

	assign setup = req.psel && !req.penable;
	assign access = req.psel && req.penable;
	assign wr_access = access && req.pwrite;

	assign sel_cfg = (req.paddr == apb_pkg::REG_CFG);
	assign sel_ctrl = (req.paddr == apb_pkg::REG_CTRL);
	assign sel_cmd = (req.paddr == apb_pkg::REG_CMD);
	assign sel_status = (req.paddr == apb_pkg::REG_STATUS);
	assign sel_known = sel_cfg || sel_ctrl || sel_cmd || sel_status;

	assign init_running = busy && !init_done; // busy before init completes

	assign start = wr_access && sel_ctrl && req.pwdata[0];
	assign push = wr_access && sel_cmd && !fifo_full; // full fifo drops the command
	assign push_data = lcd_pkg::lcd_cmd_t'(req.pwdata[9:0]);

	always_comb begin
		status_word = '0;
		status_word[0] = init_done;
		status_word[1] = busy;
		status_word[8 +: LVL_W] = fifo_level;
	end

	always_comb begin
		case (req.paddr)
			apb_pkg::REG_CFG:    rd_mux = 32'(cfg);
			apb_pkg::REG_STATUS: rd_mux = status_word;
			default:             rd_mux = '0; // ctrl and cmd are write-only
		endcase
	end

	// configuration is frozen while the init sequence reads it
	always_ff @(posedge clk) begin
		if (rst) begin
			cfg <= '0;
		end else if (wr_access && sel_cfg && !init_running) begin
			cfg <= lcd_pkg::lcd_cfg_t'(req.pwdata[6:0]);
		end
	end

	// read data captured at setup, stable through the access cycle
	always_ff @(posedge clk) begin
		if (setup && !req.pwrite) begin
			rdata_q <= rd_mux;
		end
	end

	always_comb begin
		rsp.prdata = rdata_q;
		rsp.pready = 1'b1; // no wait states
		rsp.pslverr = wr_access && ((sel_cmd && fifo_full) ||
			(sel_cfg && init_running) || !sel_known);
	end

	// an access cycle always follows its setup cycle
	a_err_in_access: assert property (@(posedge clk) disable iff (rst)
		rsp.pslverr |-> (req.psel && req.penable && $past(setup)));

endmodule

//--- rtl/cmd_fifo.sv
`timescale 1ns/1ps

module cmd_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                        clk,
	input  logic                        rst,
	input  logic                        push,
	input  lcd_pkg::lcd_cmd_t           push_data,
	input  logic                        pop,
	output logic                        valid,
	output lcd_pkg::lcd_cmd_t           data,
	output logic                        full,
	output logic [$clog2(FIFO_DEPTH):0] level
);
	localparam int PTR_W = $clog2(FIFO_DEPTH);

	lcd_pkg::lcd_cmd_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [PTR_W:0]    count;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	assign data = mem[rd_ptr]; // head visible one cycle after push
	assign valid = (count != '0);
	assign full = (count == (PTR_W + 1)'(FIFO_DEPTH));
	assign level = count;

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		push |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (rst)
		pop |-> valid);

endmodule

//--- rtl/lcd_ctrl.sv
`timescale 1ns/1ps

module lcd_ctrl #(
	parameter int CLK_PER_US = 50
) (
	input  logic               clk,
	input  logic               rst,
	input  lcd_pkg::lcd_cfg_t  cfg,
	input  logic               start,
	input  logic               valid,
	input  lcd_pkg::lcd_cmd_t  data,
	output logic               pop,
	output lcd_pkg::lcd_pins_t pins,
	output logic               init_done,
	output logic               busy
);
	localparam int DIV_W = (CLK_PER_US > 1) ? $clog2(CLK_PER_US) : 1;
	localparam int CNT_W = 10; // init runs up to 940 us

	// init timeline in us, counted from the start pulse
	localparam logic [CNT_W-1:0] FS_ON = CNT_W'(lcd_pkg::POWERUP_US);
	localparam logic [CNT_W-1:0] FS_OFF = FS_ON + CNT_W'(lcd_pkg::INIT_PULSE_US);
	localparam logic [CNT_W-1:0] DC_ON = FS_OFF + CNT_W'(lcd_pkg::CMD_CYCLE_US);
	localparam logic [CNT_W-1:0] DC_OFF = DC_ON + CNT_W'(lcd_pkg::INIT_PULSE_US);
	localparam logic [CNT_W-1:0] CL_ON = DC_OFF + CNT_W'(lcd_pkg::CMD_CYCLE_US);
	localparam logic [CNT_W-1:0] CL_OFF = CL_ON + CNT_W'(lcd_pkg::INIT_PULSE_US);
	localparam logic [CNT_W-1:0] EM_ON = CL_OFF + CNT_W'(lcd_pkg::CLEAR_WAIT_US);
	localparam logic [CNT_W-1:0] EM_OFF = EM_ON + CNT_W'(lcd_pkg::INIT_PULSE_US);
	localparam logic [CNT_W-1:0] INIT_END = EM_OFF + CNT_W'(lcd_pkg::ENTRY_WAIT_US);

	// command cycle timeline in us
	localparam logic [CNT_W-1:0] EN_ON = CNT_W'(lcd_pkg::EN_START_US);
	localparam logic [CNT_W-1:0] EN_OFF = CNT_W'(lcd_pkg::EN_END_US);
	localparam logic [CNT_W-1:0] CYCLE_END = CNT_W'(lcd_pkg::CMD_CYCLE_US);

	typedef enum logic [1:0] {
		ST_OFF,
		ST_INIT,
		ST_IDLE,
		ST_CMD
	} state_t;

	state_t             state;
	logic [DIV_W-1:0]   us_div;
	logic [CNT_W-1:0]   us_cnt;
	logic               us_tick;
	lcd_pkg::lcd_cmd_t  cmd_q;
	logic [7:0]         init_byte;
	logic               init_e;

	assign us_tick = (us_div == DIV_W'(CLK_PER_US - 1)); // last cycle of a us
	assign busy = (state == ST_INIT) || (state == ST_CMD);
	assign pop = (state == ST_IDLE) && init_done && valid;

	// microsecond counter, held at zero while not busy
	always_ff @(posedge clk) begin
		if (rst || !busy) begin
			us_div <= '0;
			us_cnt <= '0;
		end else if (us_tick) begin
			us_div <= '0;
			us_cnt <= us_cnt + 1'b1;
		end else begin
			us_div <= us_div + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_OFF;
			init_done <= 1'b0;
		end else begin
			case (state)
				ST_OFF: begin
					if (start) begin
						state <= ST_INIT;
					end
				end
				ST_INIT: begin
					if (us_tick && us_cnt == INIT_END - 1'b1) begin
						state <= ST_IDLE;
						init_done <= 1'b1;
					end
				end
				ST_IDLE: begin
					if (pop) begin
						state <= ST_CMD;
					end
				end
				default: begin
					// hold the bus for the full cycle
					if (us_tick && us_cnt == CYCLE_END - 1'b1) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			cmd_q <= data; // head taken with the pop
		end
	end

	// init instruction bytes built from the live configuration
	always_comb begin
		init_byte = 8'h00;
		init_e = 1'b0;
		if (us_cnt >= FS_ON && us_cnt < FS_OFF) begin
			init_byte = {4'b0011, cfg.lines, cfg.font, 2'b00}; // function set, 8-bit bus
			init_e = 1'b1;
		end else if (us_cnt >= DC_ON && us_cnt < DC_OFF) begin
			init_byte = {5'b00001, cfg.display_on, cfg.cursor_on, cfg.blink};
			init_e = 1'b1;
		end else if (us_cnt >= CL_ON && us_cnt < CL_OFF) begin
			init_byte = 8'h01; // clear
			init_e = 1'b1;
		end else if (us_cnt >= EM_ON && us_cnt < EM_OFF) begin
			init_byte = {6'b000001, cfg.inc_dec, cfg.shift}; // entry mode
			init_e = 1'b1;
		end
	end

	always_comb begin
		pins = '0; // bus parked low in off and idle
		case (state)
			ST_INIT: begin
				pins.e = init_e;
				pins.data = init_byte;
			end
			ST_CMD: begin
				pins.rs = cmd_q.rs;
				pins.rw = cmd_q.rw;
				pins.data = cmd_q.data;
				pins.e = (us_cnt >= EN_ON) && (us_cnt < EN_OFF);
			end
			default: begin
			end
		endcase
	end

	// command word held on the bus until the return to idle
	a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
		(state == ST_CMD) |=> (state == ST_IDLE) || (state == ST_CMD && $stable(cmd_q)));
	// e has already fallen when the bus parks
	a_e_quiet: assert property (@(posedge clk) disable iff (rst)
		(state == ST_OFF || state == ST_IDLE) |-> !pins.e && !$past(pins.e));

endmodule

//--- rtl/lcd_subsys.sv
`timescale 1ns/1ps

module lcd_subsys #(
	parameter int CLK_PER_US = 50,
	parameter int FIFO_DEPTH = 4
) (
	input  logic               clk,
	input  logic               rst,
	input  apb_pkg::apb_req_t  apb_req,
	output apb_pkg::apb_rsp_t  apb_rsp,
	output lcd_pkg::lcd_pins_t lcd
);
	localparam int LVL_W = $clog2(FIFO_DEPTH) + 1;

	lcd_pkg::lcd_cfg_t cfg;
	lcd_pkg::lcd_cmd_t push_data;
	lcd_pkg::lcd_cmd_t fifo_data;
	logic              start;
	logic              push;
	logic              pop;
	logic              fifo_full;
	logic              fifo_valid;
	logic [LVL_W-1:0]  fifo_level;
	logic              init_done;
	logic              busy;

	lcd_apb_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_regs (
		.clk        (clk),
		.rst        (rst),
		.req        (apb_req),
		.fifo_full  (fifo_full),
		.fifo_level (fifo_level),
		.init_done  (init_done),
		.busy       (busy),
		.rsp        (apb_rsp),
		.cfg        (cfg),
		.start      (start),
		.push       (push),
		.push_data  (push_data)
	);

	cmd_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk        (clk),
		.rst        (rst),
		.push       (push),
		.push_data  (push_data),
		.pop        (pop),
		.valid      (fifo_valid),
		.data       (fifo_data),
		.full       (fifo_full),
		.level      (fifo_level)
	);

	lcd_ctrl #(
		.CLK_PER_US(CLK_PER_US)
	) u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.start      (start),
		.valid      (fifo_valid),
		.data       (fifo_data),
		.pop        (pop),
		.pins       (lcd),
		.init_done  (init_done),
		.busy       (busy)
	);

endmodule

//--- testbench/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS = 40,
	parameter int RST_CYCLES = 2
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// release on a falling edge, clear of the sampling edge
	initial begin
		rst = 1'b1;
		repeat (RST_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- testbench/tb_lcd_subsys.sv
`timescale 1ns/1ps

module tb_lcd_subsys;

	localparam logic [2:0] OP_WR = 3'd0;
	localparam logic [2:0] OP_RD = 3'd1;
	localparam logic [2:0] OP_SYNC = 3'd2;   // wait for a cycle offset from start
	localparam logic [2:0] OP_PINS = 3'd3;
	localparam logic [2:0] OP_END = 3'd4;    // drain and compare captures
	localparam logic [31:0] CFG_A = 32'h5a;  // two lines, display and cursor on, increment
	localparam logic [31:0] CFG_B = 32'h25;
	// 500 us power-up, four 10 us pulses, then 50 + 50 + 200 + 100 us of waits
	localparam int INIT_CYCLES = 500 + 4 * 10 + 400;

	typedef struct packed {
		logic [2:0]  test;
		logic [2:0]  op;
		logic [3:0]  addr;
		logic [31:0] wdata;
		logic        hold;   // keep psel for a back-to-back transfer
		logic        err;
		logic [31:0] want;
	} step_t;

	logic               clk;
	logic               rst;
	apb_pkg::apb_req_t  apb_req;
	apb_pkg::apb_rsp_t  apb_rsp;
	lcd_pkg::lcd_pins_t lcd;

	step_t              steps [$];
	logic [9:0]         exp_q [$];
	int                 exp_width_q [$];
	logic [9:0]         cap_q [$];
	int                 width_q [$];
	int                 rise_q [$];
	string              test_name [6] = '{"reset", "cfg_refused", "init_seq", "cmd_pass",
		"backpressure", "status_level"};
	logic [31:0]        lfsr;
	lcd_pkg::lcd_pins_t last_pins;
	int                 e_len;
	int                 cyc = 0;
	int                 start_cyc = 0;
	int                 checked = 0;
	int                 cur_test = 0;
	int                 test_err = 0;
	int                 errors = 0;
	int                 tests_failed = 0;
	logic               timed_out = 1'b0;

	tb_clkgen #(.PERIOD_NS(40), .RST_CYCLES(2)) u_clkgen (.clk(clk), .rst(rst));

	lcd_subsys #(
		.CLK_PER_US(1),
		.FIFO_DEPTH(4)
	) dut0 (
		.clk     (clk),
		.rst     (rst),
		.apb_req (apb_req),
		.apb_rsp (apb_rsp),
		.lcd     (lcd)
	);

	always @(negedge clk) begin
		cyc <= cyc + 1;
	end

	// lcd monitor, word taken from the last cycle with e high
	always @(negedge clk) begin
		if (rst) begin
			e_len <= 0;
			last_pins <= '0;
		end else if (lcd.e) begin
			if (e_len == 0) begin
				rise_q.push_back(cyc);
			end
			e_len <= e_len + 1;
			last_pins <= lcd;
		end else if (e_len != 0) begin
			cap_q.push_back({last_pins.rs, last_pins.rw, last_pins.data});
			width_q.push_back(e_len);
			e_len <= 0;
		end
	end

	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]; // x^32 + x^22 + x^2 + x + 1
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [9:0] rand_cmd();
		logic [9:0] v;
		v = '0;
		for (int b = 0; b < 10; b++) begin
			v = {v[8:0], lfsr_step()};
		end
		return v;
	endfunction

	// hd44780 instruction bytes from the cfg fields, rs and rw low
	function automatic logic [9:0] init_word(input logic [31:0] cfg, input int idx);
		case (idx)
			0: return {2'b00, 4'b0011, cfg[6], cfg[5], 2'b00}; // function set, 8-bit
			1: return {2'b00, 5'b00001, cfg[4], cfg[3], cfg[2]};
			2: return 10'h001;
			default: return {2'b00, 6'b000001, cfg[1], cfg[0]};
		endcase
	endfunction

	task automatic add_step(input int t, input logic [2:0] op, input logic [3:0] addr,
		input logic [31:0] wdata, input logic hold, input logic err, input logic [31:0] want);
		steps.push_back('{3'(t), op, addr, wdata, hold, err, want});
	endtask

	task automatic add_word(input logic [9:0] word, input int width);
		exp_q.push_back(word);
		exp_width_q.push_back(width);
	endtask

	task automatic build_table();
		logic [9:0] cmd;
		add_step(0, OP_PINS, 4'd0, 32'd0, 1'b0, 1'b0, 32'd0);
		add_step(0, OP_RD, apb_pkg::REG_STATUS, 32'd0, 1'b0, 1'b0, 32'd0);
		add_step(0, OP_END, 4'd0, 32'd0, 1'b0, 1'b0, 32'(exp_q.size()));
		add_step(1, OP_WR, apb_pkg::REG_CFG, CFG_A, 1'b0, 1'b0, 32'd0);
		add_step(1, OP_WR, apb_pkg::REG_CTRL, 32'd1, 1'b0, 1'b0, 32'd0);
		add_step(1, OP_WR, apb_pkg::REG_CFG, CFG_B, 1'b0, 1'b1, 32'd0);
		add_step(1, OP_RD, apb_pkg::REG_CFG, 32'd0, 1'b0, 1'b0, CFG_A);
		// cfg write refused one cycle before done, status shows done one cycle after
		add_step(2, OP_SYNC, 4'd0, 32'(INIT_CYCLES - 2), 1'b0, 1'b0, 32'd0);
		add_step(2, OP_WR, apb_pkg::REG_CFG, CFG_A, 1'b1, 1'b1, 32'd0);
		add_step(2, OP_RD, apb_pkg::REG_STATUS, 32'd0, 1'b0, 1'b0, 32'h1);
		for (int k = 0; k < 4; k++) begin
			add_word(init_word(CFG_A, k), 10);
		end
		add_step(2, OP_END, 4'd0, 32'd0, 1'b0, 1'b0, 32'(exp_q.size()));
		for (int k = 0; k < 3; k++) begin
			cmd = rand_cmd();
			add_step(3, OP_WR, apb_pkg::REG_CMD, 32'(cmd), k < 2, 1'b0, 32'd0);
			add_word(cmd, 13);
		end
		add_step(3, OP_END, 4'd0, 32'd0, 1'b0, 1'b0, 32'(exp_q.size()));
		for (int k = 0; k < 6; k++) begin
			cmd = rand_cmd();
			add_step(4, OP_WR, apb_pkg::REG_CMD, 32'(cmd), k < 5, k == 5, 32'd0);
			if (k < 5) begin
				add_word(cmd, 13); // one on the bus plus four queued
			end
		end
		add_step(4, OP_END, 4'd0, 32'd0, 1'b0, 1'b0, 32'(exp_q.size()));
		for (int k = 0; k < 3; k++) begin
			cmd = rand_cmd();
			add_step(5, OP_WR, apb_pkg::REG_CMD, 32'(cmd), 1'b1, 1'b0, 32'd0);
			add_word(cmd, 13);
		end
		add_step(5, OP_RD, apb_pkg::REG_STATUS, 32'd0, 1'b0, 1'b0, 32'h203); // level 2, busy
		add_step(5, OP_END, 4'd0, 32'd0, 1'b0, 1'b0, 32'(exp_q.size()));
	endtask

	task automatic check_val(input string what, input logic [31:0] want, input logic [31:0] got);
		if (got !== want) begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", test_name[cur_test], what,
				want, got);
			errors++;
			test_err++;
		end
	endtask

	task automatic note_timeout(input string what);
		$display("TIMEOUT in test %s: %s", test_name[cur_test], what);
		timed_out = 1'b1;
		errors++;
		test_err++;
	endtask

	task automatic apb_xfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		input logic hold, output logic [31:0] rd, output logic err, output logic rdy,
		output int at);
		@(negedge clk);
		apb_req.psel = 1'b1;
		apb_req.penable = 1'b0;
		apb_req.pwrite = wr;
		apb_req.paddr = addr;
		apb_req.pwdata = wdata;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#10; // mid access cycle
		rd = apb_rsp.prdata;
		err = apb_rsp.pslverr;
		rdy = apb_rsp.pready;
		@(posedge clk);
		at = cyc;
		if (!hold) begin
			@(negedge clk);
			apb_req.psel = 1'b0;
			apb_req.penable = 1'b0;
		end
	endtask

	task automatic wait_cycle(input int target);
		int guard;
		guard = 0;
		while (cyc < target && !timed_out) begin
			@(posedge clk);
			guard++;
			if (guard > 5000) begin
				note_timeout("cycle offset never reached");
			end
		end
	endtask

	task automatic drain_check(input int n);
		int guard;
		guard = 0;
		while (cap_q.size() < n && !timed_out) begin
			@(posedge clk);
			guard++;
			if (guard > 4000) begin
				note_timeout("expected e pulses did not arrive");
			end
		end
		repeat (80) @(posedge clk); // window for an extra pulse
		check_val("capture count", 32'(n), 32'(cap_q.size()));
		for (int k = checked; k < n && k < cap_q.size(); k++) begin
			check_val("pin word", 32'(exp_q[k]), 32'(cap_q[k]));
			check_val("e width", 32'(exp_width_q[k]), 32'(width_q[k]));
			if (k > 0) begin
				check_val("start gap at least 50", 32'd1, 32'(rise_q[k] - rise_q[k - 1] >= 50));
			end
		end
		checked = n;
	endtask

	task automatic run_step(input step_t s);
		logic [31:0] rd;
		logic        err;
		logic        rdy;
		int          at;
		case (s.op)
			OP_WR, OP_RD: begin
				apb_xfer(s.op == OP_WR, s.addr, s.wdata, s.hold, rd, err, rdy, at);
				check_val("pready", 32'd1, 32'(rdy));
				check_val("pslverr", 32'(s.err), 32'(err));
				if (s.op == OP_RD) begin
					check_val("read data", s.want, rd);
				end
				if (s.op == OP_WR && s.addr == apb_pkg::REG_CTRL) begin
					start_cyc = at; // edge that samples the start write
				end
			end
			OP_SYNC: wait_cycle(start_cyc + int'(s.wdata));
			OP_PINS: begin
				@(negedge clk);
				check_val("lcd pins", s.wdata, 32'(lcd));
			end
			default: drain_check(int'(s.want));
		endcase
	endtask

	initial begin
		int guard;
		apb_req = '0;
		lfsr = 32'h171718ef;
		build_table();
		guard = 0;
		while (rst !== 1'b0 && !timed_out) begin
			@(posedge clk);
			guard++;
			if (guard > 20) begin
				note_timeout("reset never released");
			end
		end
		for (int i = 0; i < steps.size() && !timed_out; i++) begin
			if (i == 0 || steps[i].test != steps[i - 1].test) begin
				cur_test = int'(steps[i].test);
				test_err = 0;
			end
			run_step(steps[i]);
			if (timed_out || i == steps.size() - 1 || steps[i + 1].test != steps[i].test) begin
				$display("test %-13s %s (%0d errors)", test_name[cur_test],
					(test_err == 0) ? "ok" : "failed", test_err);
				if (test_err != 0) begin
					tests_failed++;
				end
			end
		end
		$display("summary: %0d tests, %0d failed, %0d errors", 6, tests_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- lcd_subsys.f
rtl/lcd_pkg.sv
rtl/apb_pkg.sv
rtl/lcd_apb_regs.sv
rtl/cmd_fifo.sv
rtl/lcd_ctrl.sv
rtl/lcd_subsys.sv
testbench/tb_clkgen.sv
testbench/tb_lcd_subsys.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lcd_subsys
FILELIST = lcd_subsys.f
BUILD    = obj_dir
LOG      = sim.log
SRCS    := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the log decides pass or fail
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
